/* all.f */
verilog/priv_check_pkg.sv
verilog/priv_insn_decode.sv
verilog/priv_csr_field_check.sv
verilog/priv_legality_check.sv
verilog/priv_mode_tracker.sv
verilog/priv_violation_report.sv
verilog/priv_monitor_top.sv
tests/priv_monitor_scoreboard.sv
tests/priv_monitor_chk.sv
tests/priv_monitor_tb.sv

/* tests/priv_monitor_chk.sv */
// Bound into priv_monitor_top; all properties are disabled while arst_n is low
`timescale 1ns/1ps

module priv_monitor_chk (
  input logic                        clk_i,
  input logic                        arst_n,
  input logic                        rvfi_valid,
  input logic                        viol_valid,
  input priv_check_pkg::viol_mask_t  sticky_mask,
  input priv_check_pkg::viol_count_t viol_count
);

  // Read by the testbench at the end of the run
  int assert_fails = 0;

  // One report per retirement, exactly one cycle later
  report_latency: assert property (@(posedge clk_i) disable iff (!arst_n)
    viol_valid == $past(rvfi_valid))
    else begin
      assert_fails++;
      $error("viol_valid does not follow rvfi_valid by one cycle");
    end

  sticky_keeps_bits: assert property (@(posedge clk_i) disable iff (!arst_n)
    (sticky_mask & $past(sticky_mask)) == $past(sticky_mask))
    else begin
      assert_fails++;
      $error("sticky_mask lost a bit");
    end

  count_monotonic: assert property (@(posedge clk_i) disable iff (!arst_n)
    viol_count >= $past(viol_count))
    else begin
      assert_fails++;
      $error("viol_count decreased");
    end

endmodule

bind priv_monitor_top priv_monitor_chk u_chk (.*);

/* tests/priv_monitor_scoreboard.sv */
// Samples on the rising edge; expects the expected mask to be valid together with rvfi_valid
`timescale 1ns/1ps

module priv_monitor_scoreboard (
  input  logic                        clk_i,
  input  logic                        arst_n,
  input  logic                        rvfi_valid,
  input  priv_check_pkg::viol_mask_t  exp_mask,
  input  logic                        viol_valid,
  input  priv_check_pkg::viol_mask_t  viol_mask,
  input  priv_check_pkg::viol_mask_t  sticky_mask,
  input  priv_check_pkg::viol_count_t viol_count,
  input  logic                        end_check,
  output int                          checks,
  output int                          errors,
  output int                          pending
);

  priv_check_pkg::viol_mask_t  exp_queue[$];
  priv_check_pkg::viol_mask_t  model_sticky;
  priv_check_pkg::viol_count_t model_count;
  logic                        end_done;

  initial begin
    checks       = 0;
    errors       = 0;
    pending      = 0;
    model_sticky = '0;
    model_count  = '0;
    end_done     = 1'b0;
  end

  task automatic compare_value(input string name, input logic [15:0] exp, input logic [15:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("ERR %0t ns %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  always @(posedge clk_i or negedge arst_n) begin
    priv_check_pkg::viol_mask_t exp;
    if (!arst_n) begin
      // A retirement still waiting here never got its report
      if (exp_queue.size() != 0) begin
        errors++;
        $display("%0d retirements lost their report to a reset", exp_queue.size());
      end
      // Reference model restarts with the DUT
      exp_queue.delete();
      model_sticky = '0;
      model_count  = '0;
    end else begin
      // Report of an earlier strobe, popped before this edge's strobe is queued
      if (viol_valid) begin
        if (exp_queue.size() == 0) begin
          errors++;
          $display("viol_valid at %0t ns with no retirement waiting for a report", $time);
        end else begin
          exp = exp_queue.pop_front();
          model_sticky = model_sticky | exp;
          if ((exp != '0) && (model_count != 16'hffff)) begin
            model_count = model_count + 16'd1;
          end
          compare_value("viol_mask", 16'(exp), 16'(viol_mask));
          compare_value("sticky_mask", 16'(model_sticky), 16'(sticky_mask));
          compare_value("viol_count", model_count, viol_count);
        end
      end
      if (rvfi_valid) begin
        exp_queue.push_back(exp_mask);
      end
      if (end_check && !end_done) begin
        end_done = 1'b1;
        if (exp_queue.size() != 0) begin
          errors++;
          $display("%0d retirements never got a report", exp_queue.size());
        end
        compare_value("sticky_mask", 16'(model_sticky), 16'(sticky_mask));
        compare_value("viol_count", model_count, viol_count);
      end
    end
    pending = exp_queue.size();
  end

endmodule

/* tests/priv_monitor_tb.sv */
// Row 1 re-applies reset so that it is again the first retirement; dcsr is always legal here
`timescale 1ns/1ps

module priv_monitor_tb;

  localparam int NUM_ROWS       = 23;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * 5 + 20;
  // Reports come one cycle after the strobe, so a few cycles is ample
  localparam int REPORT_WAIT    = 4;

  localparam logic [1:0]  M_U = 2'b00;
  localparam logic [1:0]  M_S = 2'b01;
  localparam logic [1:0]  M_M = 2'b11;
  // Flag columns, {dbg, intr, trap}; a trap row also raises rvfi_exception
  localparam logic [2:0]  F_NONE = 3'b000;
  localparam logic [2:0]  F_TRAP = 3'b001;
  localparam logic [2:0]  F_INTR = 3'b010;
  localparam logic [2:0]  F_DBG  = 3'b100;

  localparam logic [31:0] NOP           = 32'h0000_0013;
  localparam logic [31:0] MRET          = 32'h3020_0073;
  localparam logic [31:0] WFI           = 32'h1050_0073;
  localparam logic [31:0] CUSTOM0       = 32'h8c00_0073;
  // csrrs x1 on mstatus and on medeleg
  localparam logic [31:0] CSRRS_MSTATUS = 32'h3000_20f3;
  localparam logic [31:0] CSRRS_MEDELEG = 32'h3020_20f3;
  // RV32 with I and U
  localparam logic [31:0] MISA_OK       = 32'h4010_0100;
  localparam logic [31:0] MST_MPP_M     = 32'h0000_1800;
  localparam logic [31:0] MST_MPP_U     = 32'h0000_0000;
  localparam logic [31:0] MST_TW        = 32'h0020_1800;
  localparam logic [31:0] DCSR_OK       = 32'h4000_0003;

  typedef struct packed {
    logic        rst_before;
    logic [1:0]  mode;
    logic [31:0] insn;
    logic        dbg;
    logic        intr;
    logic        trap;
    logic        exc;
    logic [5:0]  cause;
    logic [31:0] misa;
    logic [31:0] mst_r;
    logic [31:0] mst_wdata;
    logic [31:0] mst_wmask;
    logic [31:0] mcounteren;
    logic [5:0]  exp_mask;
  } row_t;

  logic                        clk_i;
  logic                        arst_n;
  logic                        rvfi_valid;
  priv_check_pkg::priv_mode_t  rvfi_mode;
  priv_check_pkg::insn_t       rvfi_insn;
  logic                        rvfi_dbg_mode;
  logic                        rvfi_intr;
  logic                        rvfi_trap;
  logic                        rvfi_exception;
  priv_check_pkg::exc_cause_t  rvfi_exception_cause;
  priv_check_pkg::csr_word_t   misa_rdata;
  priv_check_pkg::csr_word_t   mstatus_rdata;
  priv_check_pkg::csr_word_t   mstatus_wdata;
  priv_check_pkg::csr_word_t   mstatus_wmask;
  priv_check_pkg::csr_word_t   mcounteren_rdata;
  priv_check_pkg::csr_word_t   dcsr_rdata;
  logic                        viol_valid;
  priv_check_pkg::viol_mask_t  viol_mask;
  priv_check_pkg::viol_mask_t  sticky_mask;
  priv_check_pkg::viol_count_t viol_count;
  priv_check_pkg::viol_mask_t  exp_mask;
  logic                        end_check;
  int                          sb_checks;
  int                          sb_errors;
  int                          sb_pending;
  int                          cycles;
  row_t                        rows [NUM_ROWS];

  priv_monitor_top dut (.*);

  priv_monitor_scoreboard u_scoreboard (
    .clk_i       (clk_i),
    .arst_n      (arst_n),
    .rvfi_valid  (rvfi_valid),
    .exp_mask    (exp_mask),
    .viol_valid  (viol_valid),
    .viol_mask   (viol_mask),
    .sticky_mask (sticky_mask),
    .viol_count  (viol_count),
    .end_check   (end_check),
    .checks      (sb_checks),
    .errors      (sb_errors),
    .pending     (sb_pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic row_t build_row(input logic [1:0] mode, input logic [31:0] insn,
                                     input logic [2:0] flags, input logic [5:0] cause,
                                     input logic [31:0] mst_r, input logic [5:0] mask);
    row_t r;
    r.rst_before = 1'b0;
    r.mode       = mode;
    r.insn       = insn;
    r.dbg        = flags[2];
    r.intr       = flags[1];
    r.trap       = flags[0];
    r.exc        = flags[0];
    r.cause      = cause;
    r.misa       = MISA_OK;
    r.mst_r      = mst_r;
    r.mst_wdata  = '0;
    r.mst_wmask  = '0;
    r.mcounteren = '0;
    r.exp_mask   = mask;
    return r;
  endfunction

  // Expected masks, bit 0 CSR_FIELD up to bit 5 RESET_MODE
  task automatic fill_table();
    rows[0]  = build_row(M_M, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b000000);
    rows[1]  = build_row(M_U, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b100000);
    rows[1].rst_before = 1'b1;
    rows[2]  = build_row(M_M, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b000001);
    rows[2].misa = 32'h4014_0100;
    rows[3]  = build_row(M_M, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b000001);
    rows[3].mst_wdata = 32'h0000_1000;
    rows[3].mst_wmask = 32'h0000_1800;
    rows[4]  = build_row(M_M, NOP,           F_NONE, 6'd0,  32'h0000_9800, 6'b000001);
    rows[5]  = build_row(M_M, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b000001);
    rows[5].mcounteren = 32'h0000_0001;
    rows[6]  = build_row(M_S, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b000010);
    rows[7]  = build_row(M_U, NOP,           F_DBG,  6'd0,  MST_MPP_M, 6'b000010);
    rows[8]  = build_row(M_U, WFI,           F_NONE, 6'd0,  MST_TW,    6'b000100);
    rows[9]  = build_row(M_U, WFI,           F_TRAP, 6'd2,  MST_TW,    6'b000000);
    rows[10] = build_row(M_M, CUSTOM0,       F_TRAP, 6'd3,  MST_MPP_M, 6'b000100);
    rows[11] = build_row(M_M, CUSTOM0,       F_TRAP, 6'd24, MST_MPP_M, 6'b000000);
    // U right after a trap
    rows[12] = build_row(M_U, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b001000);
    rows[13] = build_row(M_U, CSRRS_MSTATUS, F_NONE, 6'd0,  MST_MPP_M, 6'b000100);
    rows[14] = build_row(M_U, CSRRS_MSTATUS, F_TRAP, 6'd2,  MST_MPP_M, 6'b000000);
    rows[15] = build_row(M_M, CSRRS_MEDELEG, F_NONE, 6'd0,  MST_MPP_M, 6'b000100);
    rows[16] = build_row(M_M, CSRRS_MEDELEG, F_TRAP, 6'd24, MST_MPP_M, 6'b000000);
    rows[17] = build_row(M_M, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b000000);
    rows[18] = build_row(M_U, NOP,           F_INTR, 6'd0,  MST_MPP_M, 6'b001000);
    // MRET to U, then a retirement that stays in M
    rows[19] = build_row(M_M, MRET,          F_NONE, 6'd0,  MST_MPP_U, 6'b000000);
    rows[20] = build_row(M_M, NOP,           F_NONE, 6'd0,  MST_MPP_M, 6'b010000);
    rows[21] = build_row(M_M, MRET,          F_NONE, 6'd0,  MST_MPP_U, 6'b000000);
    rows[22] = build_row(M_M, NOP,           F_INTR, 6'd0,  MST_MPP_M, 6'b000000);
  endtask

  task automatic clear_inputs();
    rvfi_valid           = 1'b0;
    rvfi_mode            = M_M;
    rvfi_insn            = NOP;
    rvfi_dbg_mode        = 1'b0;
    rvfi_intr            = 1'b0;
    rvfi_trap            = 1'b0;
    rvfi_exception       = 1'b0;
    rvfi_exception_cause = '0;
    misa_rdata           = MISA_OK;
    mstatus_rdata        = MST_MPP_M;
    mstatus_wdata        = '0;
    mstatus_wmask        = '0;
    mcounteren_rdata     = '0;
    dcsr_rdata           = DCSR_OK;
    exp_mask             = '0;
  endtask

  task automatic apply_row(input row_t r);
    rvfi_valid           = 1'b1;
    rvfi_mode            = r.mode;
    rvfi_insn            = r.insn;
    rvfi_dbg_mode        = r.dbg;
    rvfi_intr            = r.intr;
    rvfi_trap            = r.trap;
    rvfi_exception       = r.exc;
    rvfi_exception_cause = r.cause;
    misa_rdata           = r.misa;
    mstatus_rdata        = r.mst_r;
    mstatus_wdata        = r.mst_wdata;
    mstatus_wmask        = r.mst_wmask;
    mcounteren_rdata     = r.mcounteren;
    exp_mask             = r.exp_mask;
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic wait_drive_slot();
    @(posedge clk_i);
    #2;
  endtask

  // Missing reports are left for the scoreboard to flag
  task automatic wait_for_reports();
    int waited;
    waited = 0;
    while ((sb_pending != 0) && (waited < REPORT_WAIT)) begin
      wait_drive_slot();
      waited++;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    int total;
    total = sb_errors + dut.u_chk.assert_fails + (timed_out ? 1 : 0);
    $display("checks %0d, scoreboard errors %0d, assertion failures %0d, timeouts %0d",
             sb_checks, sb_errors, dut.u_chk.assert_fails, timed_out ? 1 : 0);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    int idle;
    void'($urandom(32'h479f_6608));
    arst_n    = 1'b0;
    end_check = 1'b0;
    clear_inputs();
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    arst_n = 1'b1;
    wait_drive_slot();
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].rst_before) begin
        wait_for_reports();
        arst_n = 1'b0;
        repeat (2) wait_drive_slot();
        arst_n = 1'b1;
        wait_drive_slot();
      end
      apply_row(rows[i]);
      wait_drive_slot();
      clear_inputs();
      // Zero idle cycles gives back-to-back strobes
      idle = $urandom % 4;
      repeat (idle) wait_drive_slot();
    end
    wait_for_reports();
    end_check = 1'b1;
    wait_drive_slot();
    end_check = 1'b0;
    finish_run(1'b0);
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

endmodule

/* verilog/priv_check_pkg.sv */
// Encodings assume RV32 with only U and M modes; no N extension and no trap delegation
package priv_check_pkg;

  typedef logic [1:0]  priv_mode_t;
  typedef logic [31:0] csr_word_t;
  typedef logic [31:0] insn_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [5:0]  exc_cause_t;
  typedef logic [5:0]  viol_mask_t;
  typedef logic [15:0] viol_count_t;

  typedef enum logic [2:0] {
    INSN_OTHER,
    INSN_MRET,
    INSN_WFI,
    INSN_URET,
    INSN_CUSTOM,
    INSN_CSR
  } insn_class_t;

  typedef enum logic [1:0] {
    ST_AWAIT_FIRST,
    ST_FREE,
    ST_EXPECT_M,
    ST_EXPECT_MPP
  } tracker_state_t;

  localparam priv_mode_t MODE_U = 2'b00;
  localparam priv_mode_t MODE_M = 2'b11;

  // misa extension bits
  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // mstatus fields
  localparam int MPP_POS = 11;
  localparam int SPP_POS = 8;
  localparam int TW_POS  = 21;
  localparam int XS_POS  = 15;
  localparam int FS_POS  = 13;
  localparam int SD_POS  = 31;

  // dcsr.prv
  localparam int PRV_POS = 0;

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

  localparam insn_t MRET_INSN    = 32'b0011000_00010_00000_000_00000_1110011;
  localparam insn_t WFI_INSN     = 32'b0001000_00101_00000_000_00000_1110011;
  localparam insn_t URET_INSN    = 32'b0000000_00010_00000_000_00000_1110011;
  localparam insn_t CUSTOM0_DATA = 32'b100011_00000000000_000_00000_1110011;
  localparam insn_t CUSTOM0_MASK = 32'b111111_00000000000_111_00000_1111111;
  localparam insn_t CUSTOM1_DATA = 32'b110011_00000000000_000_00000_1110011;
  localparam insn_t CUSTOM1_MASK = 32'b111111_00000000000_111_00000_1111111;

  // N-extension registers, all absent
  localparam csr_addr_t CSR_USTATUS  = 12'h000;
  localparam csr_addr_t CSR_UIE      = 12'h004;
  localparam csr_addr_t CSR_UTVEC    = 12'h005;
  localparam csr_addr_t CSR_USCRATCH = 12'h040;
  localparam csr_addr_t CSR_UEPC     = 12'h041;
  localparam csr_addr_t CSR_UCAUSE   = 12'h042;
  localparam csr_addr_t CSR_UTVAL    = 12'h043;
  localparam csr_addr_t CSR_UIP      = 12'h044;
  // Delegation registers, absent without S or N
  localparam csr_addr_t CSR_MEDELEG  = 12'h302;
  localparam csr_addr_t CSR_MIDELEG  = 12'h303;

  localparam exc_cause_t EXC_ILLEGAL          = 6'd2;
  // Causes that win over an illegal instruction
  localparam exc_cause_t EXC_INSN_FAULT       = 6'd1;
  localparam exc_cause_t EXC_INSN_BUS_FAULT   = 6'd24;
  localparam exc_cause_t EXC_INSN_CHKSUM_FAULT = 6'd25;

  // Bit positions in viol_mask_t
  localparam int VIOL_CSR_FIELD   = 0;
  localparam int VIOL_MODE        = 1;
  localparam int VIOL_LEGALITY    = 2;
  localparam int VIOL_TRAP_MODE   = 3;
  localparam int VIOL_MRET_RETURN = 4;
  localparam int VIOL_RESET_MODE  = 5;

endpackage

/* verilog/priv_csr_field_check.sv */
// Combinational; fields are checked against a U+M core without S, N, F or extension state
`timescale 1ns/1ps

module priv_csr_field_check (
  input  logic                       rvfi_valid,
  input  priv_check_pkg::priv_mode_t rvfi_mode,
  input  logic                       rvfi_dbg_mode,
  input  priv_check_pkg::csr_word_t  misa_rdata,
  input  priv_check_pkg::csr_word_t  mstatus_rdata,
  input  priv_check_pkg::csr_word_t  mstatus_wdata,
  input  priv_check_pkg::csr_word_t  mstatus_wmask,
  input  priv_check_pkg::csr_word_t  mcounteren_rdata,
  input  priv_check_pkg::csr_word_t  dcsr_rdata,
  output logic                       field_viol,
  output logic                       mode_viol
);

  priv_check_pkg::csr_word_t  mstatus_post;
  priv_check_pkg::priv_mode_t mpp_post;
  priv_check_pkg::priv_mode_t dcsr_prv;
  logic                       misa_bad;
  logic                       mstatus_bad;

  // Written bits come from wdata, the rest keep the old value
  assign mstatus_post = (mstatus_wdata & mstatus_wmask) | (mstatus_rdata & ~mstatus_wmask);
  assign mpp_post     = mstatus_post[priv_check_pkg::MPP_POS +: 2];
  assign dcsr_prv     = dcsr_rdata[priv_check_pkg::PRV_POS +: 2];

  assign misa_bad = !misa_rdata[priv_check_pkg::MISA_U_POS] ||
                    misa_rdata[priv_check_pkg::MISA_S_POS] ||
                    misa_rdata[priv_check_pkg::MISA_N_POS];

  // No S mode and no FP or custom extension state
  assign mstatus_bad = !(mpp_post inside {priv_check_pkg::MODE_U, priv_check_pkg::MODE_M}) ||
                       mstatus_rdata[priv_check_pkg::SPP_POS] ||
                       (mstatus_rdata[priv_check_pkg::XS_POS +: 2] != 2'b00) ||
                       (mstatus_rdata[priv_check_pkg::FS_POS +: 2] != 2'b00) ||
                       mstatus_rdata[priv_check_pkg::SD_POS];

  assign field_viol = rvfi_valid &&
                      (misa_bad || mstatus_bad || (mcounteren_rdata != '0) ||
                       !(dcsr_prv inside {priv_check_pkg::MODE_U, priv_check_pkg::MODE_M}));

  // Debug mode always runs in M
  assign mode_viol = rvfi_valid &&
                     (!(rvfi_mode inside {priv_check_pkg::MODE_U, priv_check_pkg::MODE_M}) ||
                      (rvfi_dbg_mode && (rvfi_mode != priv_check_pkg::MODE_M)));

endmodule

/* verilog/priv_insn_decode.sv */
// Purely combinational; outputs only mean something while the retirement strobe is high
`timescale 1ns/1ps

module priv_insn_decode (
  input  priv_check_pkg::insn_t       rvfi_insn,
  input  priv_check_pkg::priv_mode_t  rvfi_mode,
  output priv_check_pkg::insn_class_t insn_class,
  output logic                        csr_higher_priv,
  output logic                        csr_absent
);

  priv_check_pkg::csr_addr_t csr_addr;
  logic                      is_csr;
  logic                      is_custom;

  assign csr_addr = rvfi_insn[31:20];

  // funct3 of 0 is the privileged group, 4 is the hypervisor group
  assign is_csr = (rvfi_insn[6:0] == priv_check_pkg::SYSTEM_OPCODE) &&
                  (rvfi_insn[14:12] != 3'b000) &&
                  (rvfi_insn[14:12] != 3'b100);

  assign is_custom =
    ((rvfi_insn & priv_check_pkg::CUSTOM0_MASK) == priv_check_pkg::CUSTOM0_DATA) ||
    ((rvfi_insn & priv_check_pkg::CUSTOM1_MASK) == priv_check_pkg::CUSTOM1_DATA);

  always_comb begin
    if (rvfi_insn == priv_check_pkg::MRET_INSN) begin
      insn_class = priv_check_pkg::INSN_MRET;
    end else if (rvfi_insn == priv_check_pkg::WFI_INSN) begin
      insn_class = priv_check_pkg::INSN_WFI;
    end else if (rvfi_insn == priv_check_pkg::URET_INSN) begin
      insn_class = priv_check_pkg::INSN_URET;
    end else if (is_custom) begin
      insn_class = priv_check_pkg::INSN_CUSTOM;
    end else if (is_csr) begin
      insn_class = priv_check_pkg::INSN_CSR;
    end else begin
      insn_class = priv_check_pkg::INSN_OTHER;
    end
  end

  // Address bits 9:8 carry the lowest level allowed to access the CSR
  assign csr_higher_priv = is_csr &&
                           (rvfi_mode == priv_check_pkg::MODE_U) &&
                           (csr_addr[9:8] != priv_check_pkg::MODE_U);

  // Illegal from any mode
  assign csr_absent = is_csr && (csr_addr inside {
    priv_check_pkg::CSR_USTATUS,
    priv_check_pkg::CSR_UIE,
    priv_check_pkg::CSR_UTVEC,
    priv_check_pkg::CSR_USCRATCH,
    priv_check_pkg::CSR_UEPC,
    priv_check_pkg::CSR_UCAUSE,
    priv_check_pkg::CSR_UTVAL,
    priv_check_pkg::CSR_UIP,
    priv_check_pkg::CSR_MEDELEG,
    priv_check_pkg::CSR_MIDELEG
  });

endmodule

/* verilog/priv_legality_check.sv */
// Combinational; an instruction fault or bus fault may legitimately replace the illegal trap
`timescale 1ns/1ps

module priv_legality_check (
  input  logic                        rvfi_valid,
  input  priv_check_pkg::priv_mode_t  rvfi_mode,
  input  priv_check_pkg::insn_class_t insn_class,
  input  logic                        csr_higher_priv,
  input  logic                        csr_absent,
  input  priv_check_pkg::csr_word_t   mstatus_rdata,
  input  logic                        rvfi_exception,
  input  priv_check_pkg::exc_cause_t  rvfi_exception_cause,
  output logic                        legality_viol
);

  logic in_u;
  logic wfi_trapped;
  logic expect_illegal;
  logic trap_ok;

  assign in_u = (rvfi_mode == priv_check_pkg::MODE_U);

  // TW makes WFI in U illegal
  assign wfi_trapped = (insn_class == priv_check_pkg::INSN_WFI) && in_u &&
                       mstatus_rdata[priv_check_pkg::TW_POS];

  always_comb begin
    expect_illegal = wfi_trapped || csr_higher_priv || csr_absent;
    case (insn_class)
      priv_check_pkg::INSN_CUSTOM: expect_illegal = 1'b1;
      priv_check_pkg::INSN_URET:   expect_illegal = 1'b1;
      priv_check_pkg::INSN_MRET:   expect_illegal = expect_illegal || in_u;
      default:                     expect_illegal = expect_illegal;
    endcase
  end

  assign trap_ok = rvfi_exception && (rvfi_exception_cause inside {
    priv_check_pkg::EXC_ILLEGAL,
    priv_check_pkg::EXC_INSN_FAULT,
    priv_check_pkg::EXC_INSN_BUS_FAULT,
    priv_check_pkg::EXC_INSN_CHKSUM_FAULT
  });

  assign legality_viol = rvfi_valid && expect_illegal && !trap_ok;

endmodule

/* verilog/priv_mode_tracker.sv */
// Expectations persist across idle cycles; MRET in debug mode or with a trap is not tracked
`timescale 1ns/1ps

module priv_mode_tracker (
  input  logic                        clk_i,
  input  logic                        arst_n,
  input  logic                        rvfi_valid,
  input  priv_check_pkg::priv_mode_t  rvfi_mode,
  input  logic                        rvfi_dbg_mode,
  input  logic                        rvfi_trap,
  input  logic                        rvfi_intr,
  input  priv_check_pkg::insn_class_t insn_class,
  input  priv_check_pkg::csr_word_t   mstatus_rdata,
  output logic                        trap_mode_viol,
  output logic                        mret_viol,
  output logic                        reset_mode_viol
);

  priv_check_pkg::tracker_state_t state;
  priv_check_pkg::tracker_state_t state_next;
  priv_check_pkg::priv_mode_t     expected_mode;
  logic                           in_m;
  logic                           mret_taken;

  assign in_m = (rvfi_mode == priv_check_pkg::MODE_M);

  // Only a clean MRET from M hands control to the MPP mode
  assign mret_taken = (insn_class == priv_check_pkg::INSN_MRET) && in_m &&
                      !rvfi_trap && !rvfi_dbg_mode;

  // Interrupt entry retires in M regardless of state
  assign trap_mode_viol = rvfi_valid && !in_m &&
                          (rvfi_intr || (state == priv_check_pkg::ST_EXPECT_M));

  assign mret_viol = rvfi_valid && (state == priv_check_pkg::ST_EXPECT_MPP) &&
                     !rvfi_intr && !rvfi_dbg_mode && (rvfi_mode != expected_mode);

  assign reset_mode_viol = rvfi_valid && (state == priv_check_pkg::ST_AWAIT_FIRST) && !in_m;

  always_comb begin
    state_next = state;
    if (rvfi_valid) begin
      if (rvfi_trap) begin
        state_next = priv_check_pkg::ST_EXPECT_M;
      end else if (mret_taken) begin
        state_next = priv_check_pkg::ST_EXPECT_MPP;
      end else begin
        state_next = priv_check_pkg::ST_FREE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      state <= priv_check_pkg::ST_AWAIT_FIRST;
    end else begin
      state <= state_next;
    end
  end

  // MPP as read by the MRET, checked at the next retirement
  always_ff @(posedge clk_i) begin
    if (rvfi_valid && mret_taken) begin
      expected_mode <= mstatus_rdata[priv_check_pkg::MPP_POS +: 2];
    end
  end

endmodule

/* verilog/priv_monitor_top.sv */
// Retirement inputs are sampled only with rvfi_valid; reports appear one cycle after the strobe
`timescale 1ns/1ps

module priv_monitor_top (
  input  logic                        clk_i,
  input  logic                        arst_n,
  input  logic                        rvfi_valid,
  input  priv_check_pkg::priv_mode_t  rvfi_mode,
  input  priv_check_pkg::insn_t       rvfi_insn,
  input  logic                        rvfi_dbg_mode,
  input  logic                        rvfi_intr,
  input  logic                        rvfi_trap,
  input  logic                        rvfi_exception,
  input  priv_check_pkg::exc_cause_t  rvfi_exception_cause,
  input  priv_check_pkg::csr_word_t   misa_rdata,
  input  priv_check_pkg::csr_word_t   mstatus_rdata,
  input  priv_check_pkg::csr_word_t   mstatus_wdata,
  input  priv_check_pkg::csr_word_t   mstatus_wmask,
  input  priv_check_pkg::csr_word_t   mcounteren_rdata,
  input  priv_check_pkg::csr_word_t   dcsr_rdata,
  output logic                        viol_valid,
  output priv_check_pkg::viol_mask_t  viol_mask,
  output priv_check_pkg::viol_mask_t  sticky_mask,
  output priv_check_pkg::viol_count_t viol_count
);

  priv_check_pkg::insn_class_t insn_class;
  logic                        csr_higher_priv;
  logic                        csr_absent;
  logic                        field_viol;
  logic                        mode_viol;
  logic                        legality_viol;
  logic                        trap_mode_viol;
  logic                        mret_viol;
  logic                        reset_mode_viol;

  priv_insn_decode u_decode (
    .rvfi_insn       (rvfi_insn),
    .rvfi_mode       (rvfi_mode),
    .insn_class      (insn_class),
    .csr_higher_priv (csr_higher_priv),
    .csr_absent      (csr_absent)
  );

  priv_csr_field_check u_field_check (
    .rvfi_valid       (rvfi_valid),
    .rvfi_mode        (rvfi_mode),
    .rvfi_dbg_mode    (rvfi_dbg_mode),
    .misa_rdata       (misa_rdata),
    .mstatus_rdata    (mstatus_rdata),
    .mstatus_wdata    (mstatus_wdata),
    .mstatus_wmask    (mstatus_wmask),
    .mcounteren_rdata (mcounteren_rdata),
    .dcsr_rdata       (dcsr_rdata),
    .field_viol       (field_viol),
    .mode_viol        (mode_viol)
  );

  priv_legality_check u_legality_check (
    .rvfi_valid           (rvfi_valid),
    .rvfi_mode            (rvfi_mode),
    .insn_class           (insn_class),
    .csr_higher_priv      (csr_higher_priv),
    .csr_absent           (csr_absent),
    .mstatus_rdata        (mstatus_rdata),
    .rvfi_exception       (rvfi_exception),
    .rvfi_exception_cause (rvfi_exception_cause),
    .legality_viol        (legality_viol)
  );

  // Only stateful checker
  priv_mode_tracker u_tracker (
    .clk_i           (clk_i),
    .arst_n          (arst_n),
    .rvfi_valid      (rvfi_valid),
    .rvfi_mode       (rvfi_mode),
    .rvfi_dbg_mode   (rvfi_dbg_mode),
    .rvfi_trap       (rvfi_trap),
    .rvfi_intr       (rvfi_intr),
    .insn_class      (insn_class),
    .mstatus_rdata   (mstatus_rdata),
    .trap_mode_viol  (trap_mode_viol),
    .mret_viol       (mret_viol),
    .reset_mode_viol (reset_mode_viol)
  );

  priv_violation_report u_report (
    .clk_i           (clk_i),
    .arst_n          (arst_n),
    .rvfi_valid      (rvfi_valid),
    .field_viol      (field_viol),
    .mode_viol       (mode_viol),
    .legality_viol   (legality_viol),
    .trap_mode_viol  (trap_mode_viol),
    .mret_viol       (mret_viol),
    .reset_mode_viol (reset_mode_viol),
    .viol_valid      (viol_valid),
    .viol_mask       (viol_mask),
    .sticky_mask     (sticky_mask),
    .viol_count      (viol_count)
  );

endmodule

/* verilog/priv_violation_report.sv */
// One register stage; the count saturates and the sticky mask clears only on reset
`timescale 1ns/1ps

module priv_violation_report (
  input  logic                        clk_i,
  input  logic                        arst_n,
  input  logic                        rvfi_valid,
  input  logic                        field_viol,
  input  logic                        mode_viol,
  input  logic                        legality_viol,
  input  logic                        trap_mode_viol,
  input  logic                        mret_viol,
  input  logic                        reset_mode_viol,
  output logic                        viol_valid,
  output priv_check_pkg::viol_mask_t  viol_mask,
  output priv_check_pkg::viol_mask_t  sticky_mask,
  output priv_check_pkg::viol_count_t viol_count
);

  priv_check_pkg::viol_mask_t cur_mask;

  // Checker flags are already zero outside a retirement
  always_comb begin
    cur_mask = '0;
    cur_mask[priv_check_pkg::VIOL_CSR_FIELD]   = field_viol;
    cur_mask[priv_check_pkg::VIOL_MODE]        = mode_viol;
    cur_mask[priv_check_pkg::VIOL_LEGALITY]    = legality_viol;
    cur_mask[priv_check_pkg::VIOL_TRAP_MODE]   = trap_mode_viol;
    cur_mask[priv_check_pkg::VIOL_MRET_RETURN] = mret_viol;
    cur_mask[priv_check_pkg::VIOL_RESET_MODE]  = reset_mode_viol;
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      viol_valid  <= 1'b0;
      viol_mask   <= '0;
      sticky_mask <= '0;
      viol_count  <= '0;
    end else begin
      viol_valid  <= rvfi_valid;
      viol_mask   <= cur_mask;
      sticky_mask <= sticky_mask | cur_mask;
      // One count per failing retirement, held at all ones
      if ((cur_mask != '0) && (viol_count != '1)) begin
        viol_count <= viol_count + 1'b1;
      end
    end
  end

endmodule
